// File: common/lcd_pkg.sv
package lcd_pkg;

	// one entry of the command queue, as it appears on the pins
	typedef struct packed {
		logic       rs;         // 1 for character data
		logic       rw;
		logic [7:0] data;
	} lcd_cmd_t;

	typedef struct packed {
		logic two_lines;
		logic font_5x10;
		logic display_on;
		logic cursor_on;
		logic blink_on;
		logic increment;        // entry mode direction
		logic shift;            // display shift on entry
	} lcd_cfg_t;

	typedef struct packed {
		logic       init_done;
		logic       busy;
		logic       fifo_full;
		logic [3:0] fifo_level;
	} lcd_status_t;

	localparam lcd_cfg_t LCD_CFG_DEFAULT = '{
		two_lines:  1'b1,
		font_5x10:  1'b0,
		display_on: 1'b1,
		cursor_on:  1'b0,
		blink_on:   1'b0,
		increment:  1'b1,
		shift:      1'b0
	};

	// instruction prefixes, flag bits follow
	localparam logic [3:0] LCD_FUNC_SET   = 4'b0011;      // then lines, font, 00
	localparam logic [4:0] LCD_DISP_CTRL  = 5'b00001;     // then display, cursor, blink
	localparam logic [7:0] LCD_CLEAR      = 8'b0000_0001;
	localparam logic [5:0] LCD_ENTRY_MODE = 6'b000001;    // then increment, shift

	// timing in base cycles, scaled by CLK_SCALE in the controller
	localparam int T_POWER_UP   = 500;
	localparam int T_PULSE      = 10;
	localparam int T_WAIT_SHORT = 50;
	localparam int T_WAIT_CLEAR = 200;
	localparam int T_WAIT_ENTRY = 100;
	localparam int T_WR_CYCLE   = 50;
	localparam int T_WR_E_ON    = 1;    // first base cycle with e high
	localparam int T_WR_E_LEN   = 13;

endpackage

// File: common/wb_pkg.sv
package wb_pkg;

	import lcd_pkg::*;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [1:0]  adr;
		logic [15:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [15:0] dat;
	} wb_rsp_t;

	// the two ways a write word is read
	typedef struct packed {
		logic [5:0] pad;
		lcd_cmd_t   cmd;
	} wb_cmd_word_t;

	typedef struct packed {
		logic [8:0] pad;
		lcd_cfg_t   cfg;
	} wb_cfg_word_t;

	typedef union packed {
		wb_cmd_word_t as_cmd;   // address WB_ADR_CMD
		wb_cfg_word_t as_cfg;   // address WB_ADR_CFG
	} wb_data_u;

	localparam logic [1:0] WB_ADR_CMD    = 2'd0;
	localparam logic [1:0] WB_ADR_CFG    = 2'd1;
	localparam logic [1:0] WB_ADR_STATUS = 2'd2;

endpackage

// File: hdl/lcd_cmd_fifo.sv
module lcd_cmd_fifo
	import lcd_pkg::*;
#(
	parameter int FIFO_DEPTH = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       push,
	input  lcd_cmd_t   push_data,
	output logic       full,
	output logic [3:0] level,
	output logic       valid,
	output lcd_cmd_t   head,
	input  logic       pop
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam logic [AW:0] FULL_COUNT = (AW + 1)'(FIFO_DEPTH);

	lcd_cmd_t      mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;     // depth is a power of two, wraps
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;      // both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	assign head = mem[rd_ptr];     // fall-through head
	assign valid = (count != '0);
	assign full = (count == FULL_COUNT);
	assign level = 4'(count);

	// the slave holds ack back while full, the controller pops only on valid
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> valid);

endmodule

// File: hdl/lcd_wb_slave.sv
module lcd_wb_slave
	import lcd_pkg::*;
	import wb_pkg::*;
#(
	parameter int FIFO_DEPTH = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  wb_req_t    wb_req,
	output wb_rsp_t    wb_rsp,
	output logic       push,
	output lcd_cmd_t   push_data,
	input  logic       fifo_full,
	input  logic [3:0] fifo_level,
	output lcd_cfg_t   cfg,
	output logic       reinit,
	input  logic       init_done,
	input  logic       busy
);

	wb_data_u    wdata;
	lcd_status_t status;
	logic        req;
	logic        cmd_wr;
	logic        cfg_wr;
	logic        stat_rd;
	logic        accept;
	logic        ack_q;
	logic [15:0] dat_q;

	// the status level field is four bits wide
	if (FIFO_DEPTH > 8) begin : g_depth_check
		$error("FIFO_DEPTH %0d does not fit the status level", FIFO_DEPTH);
	end

	assign wdata = wb_req.dat;
	assign req = wb_req.cyc && wb_req.stb && !ack_q;    // not again in the ack cycle
	assign cmd_wr = wb_req.we && (wb_req.adr == WB_ADR_CMD);
	assign cfg_wr = wb_req.we && (wb_req.adr == WB_ADR_CFG);
	assign stat_rd = !wb_req.we && (wb_req.adr == WB_ADR_STATUS);

	// a command write waits here while the queue is full
	assign accept = req && !(cmd_wr && fifo_full);

	assign status = '{
		init_done:  init_done,
		busy:       busy,
		fifo_full:  fifo_full,
		fifo_level: fifo_level
	};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			push <= 1'b0;
			reinit <= 1'b0;
			cfg <= LCD_CFG_DEFAULT;
		end else begin
			ack_q <= accept;
			push <= accept && cmd_wr;    // lands in the ack cycle
			reinit <= accept && cfg_wr;
			if (accept && cfg_wr)
				cfg <= wdata.as_cfg.cfg;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dat_q <= stat_rd ? 16'(status) : '0;     // other addresses read zero
			push_data <= wdata.as_cmd.cmd;
		end
	end

	assign wb_rsp = '{ack: ack_q, dat: dat_q};

	a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		ack_q |-> wb_req.cyc && wb_req.stb);

	a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		ack_q |=> !ack_q);

endmodule

// File: lcd_controller/lcd_controller.sv
module lcd_controller
	import lcd_pkg::*;
#(
	parameter int CLK_SCALE = 1
) (
	input  logic       clk,
	input  logic       rst_n,
	input  lcd_cfg_t   cfg,
	input  logic       reinit,
	input  logic       valid,
	input  lcd_cmd_t   head,
	output logic       pop,
	output logic       init_done,
	output logic       busy,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data
);

	localparam int CNT_W = $clog2(T_POWER_UP * CLK_SCALE + 1);

	typedef logic [CNT_W-1:0] cnt_t;
	typedef enum logic [1:0] {ST_POWER_UP, ST_INIT, ST_READY, ST_WRITE} state_t;

	// init sequence windows, e is high from *_ON up to *_OFF
	localparam int B_DISP  = T_PULSE + T_WAIT_SHORT;
	localparam int B_CLR   = B_DISP + T_PULSE + T_WAIT_SHORT;
	localparam int B_ENTRY = B_CLR + T_PULSE + T_WAIT_CLEAR;
	localparam int B_DONE  = B_ENTRY + T_PULSE + T_WAIT_ENTRY;

	localparam cnt_t PWR_LAST  = cnt_t'(T_POWER_UP * CLK_SCALE - 1);
	localparam cnt_t FUNC_OFF  = cnt_t'(T_PULSE * CLK_SCALE);
	localparam cnt_t DISP_ON   = cnt_t'(B_DISP * CLK_SCALE);
	localparam cnt_t DISP_OFF  = cnt_t'((B_DISP + T_PULSE) * CLK_SCALE);
	localparam cnt_t CLR_ON    = cnt_t'(B_CLR * CLK_SCALE);
	localparam cnt_t CLR_OFF   = cnt_t'((B_CLR + T_PULSE) * CLK_SCALE);
	localparam cnt_t ENTRY_ON  = cnt_t'(B_ENTRY * CLK_SCALE);
	localparam cnt_t ENTRY_OFF = cnt_t'((B_ENTRY + T_PULSE) * CLK_SCALE);
	localparam cnt_t INIT_LAST = cnt_t'(B_DONE * CLK_SCALE - 1);
	localparam cnt_t WR_E_ON   = cnt_t'(T_WR_E_ON * CLK_SCALE);
	localparam cnt_t WR_E_OFF  = cnt_t'((T_WR_E_ON + T_WR_E_LEN) * CLK_SCALE);
	localparam cnt_t WR_LAST   = cnt_t'(T_WR_CYCLE * CLK_SCALE);

	state_t   state;
	state_t   state_nxt;
	cnt_t     cnt;
	cnt_t     cnt_nxt;
	logic     reinit_pend;    // reinit seen during a write cycle
	lcd_cmd_t cmd_q;
	lcd_cmd_t cmd_nxt;
	lcd_cmd_t pins_nxt;
	logic     e_nxt;

	always_comb begin
		state_nxt = state;
		cnt_nxt = cnt + 1'b1;
		pop = 1'b0;
		case (state)
			ST_POWER_UP: begin
				if (reinit || cnt == PWR_LAST) begin     // reinit skips the wait
					state_nxt = ST_INIT;
					cnt_nxt = '0;
				end
			end
			ST_INIT: begin
				if (reinit) begin
					cnt_nxt = '0;
				end else if (cnt == INIT_LAST) begin
					state_nxt = ST_READY;
					cnt_nxt = '0;
				end
			end
			ST_READY: begin
				cnt_nxt = '0;
				if (reinit) begin
					state_nxt = ST_INIT;
				end else if (valid) begin
					state_nxt = ST_WRITE;
					pop = 1'b1;
				end
			end
			default: begin
				// a write cycle always runs to its end, so the popped command is not lost
				if (cnt == WR_LAST) begin
					state_nxt = (reinit || reinit_pend) ? ST_INIT : ST_READY;
					cnt_nxt = '0;
				end
			end
		endcase
	end

	assign cmd_nxt = pop ? head : cmd_q;

	// pins are registered from the next state and count
	always_comb begin
		e_nxt = 1'b0;
		pins_nxt = '0;
		if (state_nxt == ST_INIT) begin
			if (cnt_nxt < FUNC_OFF) begin
				e_nxt = 1'b1;
				pins_nxt.data = {LCD_FUNC_SET, cfg.two_lines, cfg.font_5x10, 2'b00};
			end else if (cnt_nxt >= DISP_ON && cnt_nxt < DISP_OFF) begin
				e_nxt = 1'b1;
				pins_nxt.data = {LCD_DISP_CTRL, cfg.display_on, cfg.cursor_on, cfg.blink_on};
			end else if (cnt_nxt >= CLR_ON && cnt_nxt < CLR_OFF) begin
				e_nxt = 1'b1;
				pins_nxt.data = LCD_CLEAR;
			end else if (cnt_nxt >= ENTRY_ON && cnt_nxt < ENTRY_OFF) begin
				e_nxt = 1'b1;
				pins_nxt.data = {LCD_ENTRY_MODE, cfg.increment, cfg.shift};
			end
		end else if (state_nxt == ST_WRITE) begin
			pins_nxt = cmd_nxt;                           // held for the whole cycle
			e_nxt = (cnt_nxt >= WR_E_ON) && (cnt_nxt < WR_E_OFF);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_POWER_UP;
			cnt <= '0;
			reinit_pend <= 1'b0;
			init_done <= 1'b0;
			busy <= 1'b1;
			e <= 1'b0;
			rs <= 1'b0;
			rw <= 1'b0;
			lcd_data <= '0;
		end else begin
			state <= state_nxt;
			cnt <= cnt_nxt;
			reinit_pend <= (reinit_pend || reinit) && (state_nxt != ST_INIT);
			busy <= (state_nxt != ST_READY);
			if (state_nxt == ST_INIT)
				init_done <= 1'b0;
			else if (state_nxt == ST_READY)
				init_done <= 1'b1;
			e <= e_nxt;
			rs <= pins_nxt.rs;
			rw <= pins_nxt.rw;
			lcd_data <= pins_nxt.data;
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			cmd_q <= head;
	end

	// idle stays idle until the queue or the bus side asks for something
	a_ready_hold: assert property (@(posedge clk) disable iff (!rst_n)
		state == ST_READY && !valid && !reinit |=> state == ST_READY);

endmodule

// File: hdl/lcd_top.sv
module lcd_top
	import lcd_pkg::*;
	import wb_pkg::*;
#(
	parameter int CLK_SCALE  = 1,
	parameter int FIFO_DEPTH = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  wb_req_t    wb_req,
	output wb_rsp_t    wb_rsp,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data
);

	logic       push;
	lcd_cmd_t   push_data;
	logic       fifo_full;
	logic [3:0] fifo_level;
	logic       fifo_valid;
	lcd_cmd_t   fifo_head;
	logic       pop;
	lcd_cfg_t   cfg;
	logic       reinit;
	logic       init_done;
	logic       busy;

	lcd_wb_slave #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) wb_slave_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.push       (push),
		.push_data  (push_data),
		.fifo_full  (fifo_full),
		.fifo_level (fifo_level),
		.cfg        (cfg),
		.reinit     (reinit),
		.init_done  (init_done),
		.busy       (busy)
	);

	lcd_cmd_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) cmd_fifo_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.push_data (push_data),
		.full      (fifo_full),
		.level     (fifo_level),
		.valid     (fifo_valid),
		.head      (fifo_head),
		.pop       (pop)
	);

	lcd_controller #(
		.CLK_SCALE (CLK_SCALE)
	) controller_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.reinit    (reinit),
		.valid     (fifo_valid),
		.head      (fifo_head),
		.pop       (pop),
		.init_done (init_done),
		.busy      (busy),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data)
	);

endmodule

// File: sim/tb_lcd_top.sv
module tb_lcd_top
	import lcd_pkg::*;
	import wb_pkg::*;
();

	logic        clk;
	logic        rst_n;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic        e;
	logic        rs;
	logic        rw;
	logic [7:0]  lcd_data;

	lcd_cmd_t    strobes[$];      // one entry per rising edge of e
	int          strobe_cnt = 0;
	logic        e_prev = 1'b0;
	byte         ops[$];
	logic [15:0] fld_a[$];
	logic [15:0] fld_b[$];
	logic [15:0] fld_c[$];
	int          errors = 0;
	int          passed = 0;
	int          cycles = 0;
	int          limit = 0;

	lcd_top #(
		.CLK_SCALE  (1),
		.FIFO_DEPTH (4)
	) dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data)
	);

	always #4 clk = ~clk;

	// pins settle before the falling edge
	always @(negedge clk) begin
		if (rst_n && e && !e_prev) begin
			strobes.push_back('{rs: rs, rw: rw, data: lcd_data});
			strobe_cnt++;
		end
		e_prev = e;
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic check_strobe(input lcd_cmd_t got, input lcd_cmd_t exp, output logic ok);
		ok = (got === exp);
		if (!ok)
			$display("Mismatch at %0t: strobe rs=%b rw=%b data=%02h, expected rs=%b rw=%b data=%02h",
				$time, got.rs, got.rw, got.data, exp.rs, exp.rw, exp.data);
	endtask

	task automatic check_status(input lcd_status_t got, input lcd_status_t exp,
			input logic [8:0] upper, output logic ok);
		ok = (got === exp) && (upper === '0);
		if (!ok)
			$display("Mismatch at %0t: status %07b upper %03h, expected %07b upper 000",
				$time, got, upper, exp);
	endtask

	task automatic idle_gap();
		repeat ($urandom_range(3)) @(negedge clk);
	endtask

	// ack is seen at a falling edge, request dropped one edge later
	task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [15:0] wdat,
			output logic [15:0] rdat);
		@(negedge clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		@(negedge clk);
		while (!wb_rsp.ack)
			@(negedge clk);
		rdat = wb_rsp.dat;
		@(negedge clk);
		wb_req = '0;
	endtask

	// strobe count first, then poll busy until the controller is back in ready
	task automatic wait_idle(input int count);
		logic [15:0] rdat;
		lcd_status_t st;
		while (strobe_cnt < count)
			@(negedge clk);
		bus_cycle(1'b0, WB_ADR_STATUS, '0, rdat);
		st = lcd_status_t'(rdat[6:0]);
		while (st.busy) begin
			bus_cycle(1'b0, WB_ADR_STATUS, '0, rdat);
			st = lcd_status_t'(rdat[6:0]);
		end
	endtask

	task automatic run_tests();
		int          i;
		byte         op;
		logic [15:0] rdat;
		lcd_cmd_t    got;
		lcd_cmd_t    exp;
		logic        ok;
		for (i = 0; i < ops.size(); i++) begin
			op = ops[i];
			ok = 1'b1;
			case (op)
				"W": begin
					idle_gap();
					bus_cycle(1'b1, fld_a[i][1:0], fld_b[i], rdat);
				end
				"R": begin
					idle_gap();
					bus_cycle(1'b0, fld_a[i][1:0], '0, rdat);
					check_status(lcd_status_t'(rdat[6:0]), lcd_status_t'(fld_b[i][6:0]),
						rdat[15:7], ok);
				end
				"E": begin
					while (strobes.size() == 0)
						@(negedge clk);
					got = strobes.pop_front();
					exp = '{rs: fld_a[i][0], rw: fld_b[i][0], data: fld_c[i][7:0]};
					check_strobe(got, exp, ok);
				end
				"D": wait_idle(int'(fld_a[i]));
				default: begin
					$display("Test file holds an unknown operation '%c'", op);
					ok = 1'b0;
				end
			endcase
			if (ok)
				passed++;
			else
				errors++;
			$display("test %0d %c %h %h %h: %s", i, op, fld_a[i], fld_b[i], fld_c[i],
				ok ? "ok" : "failed");
		end
	endtask

	initial begin
		int          fd;
		int          n_e;
		int          n_cfg;
		string       line;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		clk = 1'b0;
		rst_n = 1'b0;
		wb_req = '0;
		n_e = 0;
		n_cfg = 0;
		void'($urandom(72609));
		fd = $fopen("sim/lcd_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file sim/lcd_tests.txt");
			$display("TEST FAIL");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 2 && line[0] != "#") begin
					a = '0;
					b = '0;
					c = '0;
					void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, b, c));
					ops.push_back(line[0]);
					fld_a.push_back(a);
					fld_b.push_back(b);
					fld_c.push_back(c);
					if (line[0] == "E")
						n_e++;
					if (line[0] == "W" && a == 16'(WB_ADR_CFG))
						n_cfg++;
				end
			end
			$fclose(fd);
			limit = (n_e * 60 + n_cfg * 460 + 600) * 2;
			repeat (4) @(negedge clk);
			rst_n = 1'b1;
			run_tests();
			$display("%0d tests run, %0d passed, %0d failed", ops.size(), passed, errors);
			if (errors == 0)
				$display("TEST PASS");
			else
				$display("TEST FAIL");
			$finish;
		end
	end

endmodule

// File: sim/lcd_tests.txt
# all fields hex: W adr data | R adr status | E rs rw byte | D strobe_count
# W bus write, R bus read and compare, E next strobe, D wait for strobes then idle
R 2 0020
E 0 0 38
E 0 0 0C
E 0 0 01
E 0 0 06
W 0 0248
W 0 0269
W 0 00C0
W 0 0100
W 0 0241
W 0 0242
E 1 0 48
E 1 0 69
E 0 0 C0
E 0 1 00
E 1 0 41
E 1 0 42
D 0A
W 0 0258
W 0 0259
W 1 003D
E 1 0 58
E 0 0 34
E 0 0 0F
E 0 0 01
E 0 0 05
E 1 0 59
D 10
R 2 0040
R 0 0000
R 1 0000
R 3 0000

// File: files.f
common/lcd_pkg.sv
common/wb_pkg.sv
hdl/lcd_cmd_fifo.sv
hdl/lcd_wb_slave.sv
lcd_controller/lcd_controller.sv
hdl/lcd_top.sv
sim/tb_lcd_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_lcd_top -f files.f -o tb_lcd_top || exit 1
./obj_dir/tb_lcd_top > sim.log 2>&1 || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
